// ==== Makefile ====
# Verilator flow for the decode stage

VERILATOR  = verilator
TOP        = decode_tb
RTL_TOP    = decode
FILELIST   = decode.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Status comes from the pass line in the simulation output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/decode_tb.sv ====
`timescale 1ns/10ps
`include "decode_params.svh"

module decode_tb;
   import decode_pkg::*;

   localparam int HALF_PERIOD = 50;
   localparam int NUM_CYCLES = 500;
   // 1 ns poll steps before a missing edge counts
   localparam int EDGE_TIMEOUT = 200;

   // Result groups
   localparam int T_RESET = 0;
   localparam int T_DECODE = 1;
   localparam int T_REGS = 2;
   localparam int T_BYPASS = 3;
   localparam int T_SQUASH = 4;
   localparam int T_PASS = 5;
   localparam int NUM_TESTS = 6;

   logic       clk = 1'b0;
   logic       reset;
   logic       squash;
   fetch_t     fetch_in;
   writeback_t wb_in;
   id_ex_t     id_ex_out;
   reg_sel_t   rd;
   logic       reg_wrt_now;

   integer      seed;
   logic [31:0] rnd;

   // Shadow register file
   word_t shadow [`NUM_REGS];

   // Expected ID/EX after the coming edge
   id_ex_t exp_id_ex;
   logic   prev_squash;
   logic   prev_byp1;
   logic   prev_byp2;

   int   check_count [NUM_TESTS];
   int   err_count [NUM_TESTS];
   logic timed_out;
   int   cycle;
   int   total_checks;
   int   total_errs;

   decode dut (
      .clk         (clk),
      .reset       (reset),
      .fetch_in    (fetch_in),
      .wb_in       (wb_in),
      .squash      (squash),
      .id_ex_out   (id_ex_out),
      .rd          (rd),
      .reg_wrt_now (reg_wrt_now)
   );

   always #(HALF_PERIOD) clk = ~clk;

   ////////////////////
   // Decode model
   ////////////////////

   function automatic logic writes_reg(input opcode_t op);
      logic wrt;
      wrt = 1'b1;
      // Branches
      if (op[4:2] == 3'b011) begin
         wrt = 1'b0;
      // halt, nop, siic, rti, j, jr
      end else if (op[4:3] == 2'b00 && op[2:1] != 2'b11) begin
         wrt = 1'b0;
      // st
      end else if (op == 5'b10000) begin
         wrt = 1'b0;
      end
      return wrt;
   endfunction

   function automatic reg_sel_t dest_of(input instr_t instr);
      opcode_t  op;
      reg_sel_t sel;
      op = instr[15:11];
      if (op == 5'b11011 || op == 5'b11010 || op[4:2] == 3'b111) begin
         sel = instr[4:2];
      end else if (op[4:1] == 4'b0011) begin
         // Link register
         sel = 3'd7;
      end else if (op == 5'b11000 || op == 5'b10010 || op == 5'b10011) begin
         sel = instr[10:8];
      end else begin
         sel = instr[7:5];
      end
      return sel;
   endfunction

   function automatic string test_label(input int test);
      case (test)
         T_RESET:  return "reset";
         T_DECODE: return "decode_rules";
         T_REGS:   return "reg_reads";
         T_BYPASS: return "bypass";
         T_SQUASH: return "squash";
         default:  return "pass_through";
      endcase
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_word(input int test, input string name, input word_t exp,
                             input word_t act);
      check_count[test]++;
      if (act !== exp) begin
         err_count[test]++;
         $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_sel(input int test, input string name, input reg_sel_t exp,
                            input reg_sel_t act);
      check_count[test]++;
      if (act !== exp) begin
         err_count[test]++;
         $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input int test, input string name, input logic exp,
                            input logic act);
      check_count[test]++;
      if (act !== exp) begin
         err_count[test]++;
         $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   task automatic check_instr(input int test, input string name, input instr_t exp,
                              input instr_t act);
      check_count[test]++;
      if (act !== exp) begin
         err_count[test]++;
         $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   ////////////////////
   // Sequencing
   ////////////////////

   // Polls off the ns grid, so it never lands on an edge
   task automatic wait_rise();
      int   steps;
      logic prev;
      steps = 0;
      prev = clk;
      #0.5;
      while (!(prev === 1'b0 && clk === 1'b1) && steps < EDGE_TIMEOUT) begin
         prev = clk;
         #1;
         steps++;
      end
      if (steps >= EDGE_TIMEOUT) begin
         timed_out = 1'b1;
         $display("Timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT);
      end
   endtask

   task automatic drive_random();
      rnd = $random(seed);
      fetch_in.instruction = rnd[15:0];
      fetch_in.incr_pc = rnd[31:16];
      rnd = $random(seed);
      fetch_in.unaligned_error = rnd[0];
      // About 1 in 8
      squash = (rnd[3:1] == 3'b000);
      wb_in.reg_wrt = rnd[4];
      // One write in four aimed at Rs
      if (rnd[6:5] == 2'b00) begin
         wb_in.write_reg = fetch_in.instruction[10:8];
      end else begin
         wb_in.write_reg = rnd[9:7];
      end
      wb_in.write_data = rnd[31:16];
   endtask

   // Same-cycle outputs, then next ID/EX and shadow update
   task automatic step_model();
      instr_t   eff;
      reg_sel_t rs;
      reg_sel_t rt;
      logic     wrt;
      int       test;
      eff = squash ? instr_t'(`NOP_INSTR) : fetch_in.instruction;
      wrt = writes_reg(eff[15:11]);
      test = squash ? T_SQUASH : T_DECODE;
      check_sel(test, "rd", dest_of(eff), rd);
      check_bit(test, "reg_wrt_now", wrt, reg_wrt_now);
      rs = eff[10:8];
      rt = eff[7:5];
      prev_byp1 = wb_in.reg_wrt && (wb_in.write_reg == rs);
      prev_byp2 = wb_in.reg_wrt && (wb_in.write_reg == rt);
      exp_id_ex.instruction = eff;
      exp_id_ex.incr_pc = fetch_in.incr_pc;
      exp_id_ex.r1 = prev_byp1 ? wb_in.write_data : shadow[rs];
      exp_id_ex.r2 = prev_byp2 ? wb_in.write_data : shadow[rt];
      exp_id_ex.reg_wrt = squash ? 1'b0 : wrt;
      exp_id_ex.unaligned_error = fetch_in.unaligned_error;
      prev_squash = squash;
      if (wb_in.reg_wrt) begin
         shadow[wb_in.write_reg] = wb_in.write_data;
      end
   endtask

   task automatic compare_id_ex();
      int ctl;
      ctl = prev_squash ? T_SQUASH : T_DECODE;
      check_instr(ctl, "id_ex_out.instruction", exp_id_ex.instruction, id_ex_out.instruction);
      check_bit(ctl, "id_ex_out.reg_wrt", exp_id_ex.reg_wrt, id_ex_out.reg_wrt);
      check_word(prev_byp1 ? T_BYPASS : T_REGS, "id_ex_out.r1", exp_id_ex.r1, id_ex_out.r1);
      check_word(prev_byp2 ? T_BYPASS : T_REGS, "id_ex_out.r2", exp_id_ex.r2, id_ex_out.r2);
      check_word(T_PASS, "id_ex_out.incr_pc", exp_id_ex.incr_pc, id_ex_out.incr_pc);
      check_bit(T_PASS, "id_ex_out.unaligned_error", exp_id_ex.unaligned_error,
                id_ex_out.unaligned_error);
   endtask

   initial begin
      seed = 32'h3c51_f697;
      reset = 1'b1;
      squash = 1'b0;
      fetch_in = '0;
      wb_in = '0;
      timed_out = 1'b0;
      total_checks = 0;
      total_errs = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         check_count[t] = 0;
         err_count[t] = 0;
      end
      for (int i = 0; i < `NUM_REGS; i++) begin
         shadow[i] = '0;
      end

      // Two edges in reset
      wait_rise();
      if (!timed_out) begin
         #0.5;
         wait_rise();
      end
      if (!timed_out) begin
         #0.5;
         reset = 1'b0;
         #97;
         check_instr(T_RESET, "id_ex_out.instruction", `NOP_INSTR, id_ex_out.instruction);
         check_bit(T_RESET, "id_ex_out.reg_wrt", 1'b0, id_ex_out.reg_wrt);
         check_bit(T_RESET, "id_ex_out.unaligned_error", 1'b0, id_ex_out.unaligned_error);
         check_word(T_RESET, "id_ex_out.r1", '0, id_ex_out.r1);
         check_word(T_RESET, "id_ex_out.r2", '0, id_ex_out.r2);
         step_model();
         $display("test %s: %0d checks, %0d errors", test_label(T_RESET),
                  check_count[T_RESET], err_count[T_RESET]);
      end

      // Drive at edge + 1, sample at edge + 98
      cycle = 0;
      while (!timed_out && cycle < NUM_CYCLES) begin
         wait_rise();
         if (!timed_out) begin
            #0.5;
            drive_random();
            #97;
            compare_id_ex();
            step_model();
         end
         cycle++;
      end

      ////////////////////
      // Report
      ////////////////////

      for (int t = 1; t < NUM_TESTS; t++) begin
         $display("test %s: %0d checks, %0d errors", test_label(t),
                  check_count[t], err_count[t]);
      end
      for (int t = 0; t < NUM_TESTS; t++) begin
         total_checks += check_count[t];
         total_errs += err_count[t];
      end
      if (check_count[T_BYPASS] == 0 || check_count[T_SQUASH] == 0) begin
         $display("Random stimulus never produced a bypass or a squash case");
         total_errs++;
      end
      $display("Totals: %0d checks, %0d errors", total_checks, total_errs);
      if (timed_out || total_errs != 0) begin
         $display("Regression failed");
      end else begin
         $display("Regression passed");
      end
      $finish;
   end

endmodule

// ==== decode.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/instr_control.sv
verilog/reg_file_bypass.sv
verilog/decode.sv
bench/decode_tb.sv

// ==== verilog/decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "decode_params.svh"

module decode (
   input  logic                   clk,
   input  logic                   reset,
   input  decode_pkg::fetch_t     fetch_in,
   input  decode_pkg::writeback_t wb_in,
   input  logic                   squash,
   output decode_pkg::id_ex_t     id_ex_out,
   output decode_pkg::reg_sel_t   rd,
   output logic                   reg_wrt_now
);
   import decode_pkg::*;

   ////////////////////
   // Internal signals
   ////////////////////

   // Instruction after squash substitution
   instr_t instr_eff;
   logic   reg_wrt;
   word_t  r1;
   word_t  r2;

   // Next ID/EX contents
   id_ex_t id_ex_d;

   // Squash turns the slot into a bubble
   assign instr_eff = squash ? instr_t'(`NOP_INSTR) : fetch_in.instruction;

   ////////////////////
   // Control decode
   ////////////////////

   instr_control u_instr_control (
      .instruction (instr_eff),
      .reg_wrt     (reg_wrt),
      .dest        (rd)
   );

   // Seen by hazard logic this same cycle
   assign reg_wrt_now = reg_wrt;

   ////////////////////
   // Register file
   ////////////////////

   // Rs at 10:8, Rt at 7:5
   reg_file_bypass u_reg_file (
      .clk        (clk),
      .reset      (reset),
      .read1_sel  (instr_eff[10:8]),
      .read2_sel  (instr_eff[7:5]),
      .wb         (wb_in),
      .read1_data (r1),
      .read2_data (r2)
   );

   ////////////////////
   // ID/EX register
   ////////////////////

   always_comb begin
      id_ex_d.instruction     = instr_eff;
      id_ex_d.incr_pc         = fetch_in.incr_pc;
      id_ex_d.r1              = r1;
      id_ex_d.r2              = r2;
      // Squashed slot decodes as NOP, which never writes
      id_ex_d.reg_wrt         = reg_wrt;
      // Fault flag travels even through a squash
      id_ex_d.unaligned_error = fetch_in.unaligned_error;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex_out             <= '0;
         id_ex_out.instruction <= `NOP_INSTR;
      end else begin
         id_ex_out <= id_ex_d;
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   // Bubble must not write back downstream
   squash_no_write: assert property (
      @(posedge clk) disable iff (reset)
      squash |=> !id_ex_out.reg_wrt
   ) else $error("reg_wrt set in ID/EX after a squash");

   // Execute sees a NOP out of reset
   reset_gives_nop: assert property (
      @(posedge clk)
      reset |=> (id_ex_out.instruction == `NOP_INSTR)
   ) else $error("ID/EX instruction is not NOP after reset");

endmodule
`default_nettype wire

// ==== verilog/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

////////////////////
// Datapath widths
////////////////////

// Data, PC and instruction share one width
`define WORD_W 16

// General registers, r7 doubles as link register
`define NUM_REGS 8
`define REG_SEL_W 3

////////////////////
// Encodings
////////////////////

// Injected on squash, also the ID/EX reset value
`define NOP_INSTR 16'h0800

`endif

// ==== verilog/decode_pkg.sv ====
`include "decode_params.svh"

package decode_pkg;

   ////////////////////
   // Plain vectors
   ////////////////////

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`WORD_W-1:0] pc_t;
   typedef logic [`WORD_W-1:0] instr_t;

   // Top five bits of the instruction
   typedef logic [4:0] opcode_t;

   typedef logic [`REG_SEL_W-1:0] reg_sel_t;

   ////////////////////
   // Stage bundles
   ////////////////////

   // From fetch, one per cycle
   typedef struct packed {
      instr_t instruction;
      pc_t    incr_pc;
      logic   unaligned_error;
   } fetch_t;

   // Write request coming back from write-back
   typedef struct packed {
      logic     reg_wrt;
      reg_sel_t write_reg;
      word_t    write_data;
   } writeback_t;

   // ID/EX pipeline register contents
   typedef struct packed {
      instr_t instruction;
      pc_t    incr_pc;
      word_t  r1;
      word_t  r2;
      logic   reg_wrt;
      logic   unaligned_error;
   } id_ex_t;

endpackage

// ==== verilog/instr_control.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "decode_params.svh"

module instr_control (
   input  decode_pkg::instr_t   instruction,
   output logic                 reg_wrt,
   output decode_pkg::reg_sel_t dest
);
   import decode_pkg::*;

   // Where the destination field sits
   typedef enum logic [1:0] {
      FMT_R,
      FMT_LINK,
      FMT_I_HI,
      FMT_I_LO
   } fmt_e;

   opcode_t opcode;
   fmt_e    fmt;

   assign opcode = instruction[15:11];

   ////////////////////
   // Register write
   ////////////////////

   always_comb begin
      reg_wrt = 1'b1;
      casez (opcode)
         // Conditional branches
         5'b011??: reg_wrt = 1'b0;
         // halt, nop
         5'b0000?: reg_wrt = 1'b0;
         // siic, rti
         5'b0001?: reg_wrt = 1'b0;
         // j, jr without link
         5'b0010?: reg_wrt = 1'b0;
         // Store only touches memory
         5'b10000: reg_wrt = 1'b0;
         default:  reg_wrt = 1'b1;
      endcase
   end

   ////////////////////
   // Format select
   ////////////////////

   always_comb begin
      fmt = FMT_I_LO;
      casez (opcode)
         // ALU register-register group
         5'b11011,
         5'b11010,
         5'b111??: fmt = FMT_R;
         // jal, jalr
         5'b0011?: fmt = FMT_LINK;
         // lbi, slbi, stu write the Rs field
         5'b11000,
         5'b10010,
         5'b10011: fmt = FMT_I_HI;
         default:  fmt = FMT_I_LO;
      endcase
   end

   // Destination register per format
   always_comb begin
      case (fmt)
         FMT_R:    dest = instruction[4:2];
         // Return address always lands in r7
         FMT_LINK: dest = reg_sel_t'(`NUM_REGS - 1);
         FMT_I_HI: dest = instruction[10:8];
         default:  dest = instruction[7:5];
      endcase
   end

endmodule
`default_nettype wire

// ==== verilog/reg_file_bypass.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "decode_params.svh"

module reg_file_bypass (
   input  logic                   clk,
   input  logic                   reset,
   input  decode_pkg::reg_sel_t   read1_sel,
   input  decode_pkg::reg_sel_t   read2_sel,
   input  decode_pkg::writeback_t wb,
   output decode_pkg::word_t      read1_data,
   output decode_pkg::word_t      read2_data
);
   import decode_pkg::*;

   // Storage for r0..r7
   word_t regs [`NUM_REGS];

   ////////////////////
   // Write port
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.reg_wrt) begin
         regs[wb.write_reg] <= wb.write_data;
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   // Same-cycle write wins over the stored word
   function automatic word_t bypass_read(
      input reg_sel_t   sel,
      input word_t      stored,
      input writeback_t req
   );
      word_t result;
      if (req.reg_wrt && (req.write_reg == sel)) begin
         result = req.write_data;
      end else begin
         result = stored;
      end
      return result;
   endfunction

   always_comb begin
      read1_data = bypass_read(read1_sel, regs[read1_sel], wb);
   end

   always_comb begin
      read2_data = bypass_read(read2_sel, regs[read2_sel], wb);
   end

   ////////////////////
   // Checks
   ////////////////////

   // Enabled write must name a real register,
   // otherwise an X select would smear the array
   write_sel_known: assert property (
      @(posedge clk) disable iff (reset)
      wb.reg_wrt |-> !$isunknown(wb.write_reg)
   ) else $error("write-back select unknown while reg_wrt is high");

endmodule
`default_nettype wire
